/* filelist.f */
hw/exPkg.sv
hw/exStageIf.sv
hw/uopIngress.sv
hw/exAlu.sv
hw/exMemAccess.sv
hw/exWriteback.sv
hw/exPipeTop.sv
tb/exPipeTb.sv

/* hw/exAlu.sv */
//******************************
// EX1 stage with ALU, compares,
// T flag and predicate squash
//******************************
`default_nettype none

module exAlu
	import exPkg::*;
#(
	parameter int DATA_W = exPkg::DATA_W
) (
	input  wire   clock,
	input  wire   rstN,
	exStageIf.dst in,
	exStageIf.src out
);

	typedef logic [DATA_W-1:0] word_t;

	word_t opA;
	word_t opB;
	word_t opImm;
	word_t aluRes;	// Result or memory address
	logic  tFlag;	// Predicate flag, written by compares
	logic  predOk;
	logic  opLive;	// Op survives the predicate
	logic  accept;
	logic  isCmp;
	logic  cmpRes;

	assign opA   = word_t'(in.uop.valA);
	assign opB   = word_t'(in.uop.valB);
	assign opImm = word_t'(in.uop.valImm);

	assign in.ready = !out.valid || out.ready;	// Moves when own op leaves
	assign accept   = in.valid && in.ready;

	always_comb begin
		case (in.uop.pred)
			ALWAYS:  predOk = 1'b1;
			IFT:     predOk = tFlag;
			IFF:     predOk = !tFlag;
			default: predOk = 1'b0;	// Reserved mode never runs
		endcase
	end

	assign opLive = in.uop.live && predOk;

	always_comb begin
		aluRes = '0;
		isCmp  = 1'b0;
		cmpRes = 1'b0;
		case (in.uop.cmd)
			ADD:  aluRes = opA + opB;
			SUB:  aluRes = opA - opB;
			AND:  aluRes = opA & opB;
			OR:   aluRes = opA | opB;
			XOR:  aluRes = opA ^ opB;
			SHL:  aluRes = opA << opB[4:0];
			MOVI: aluRes = opImm;
			CMPEQ: begin
				isCmp  = 1'b1;
				cmpRes = (opA == opB);
			end
			CMPLT: begin
				isCmp  = 1'b1;
				cmpRes = (opA < opB);	// Unsigned
			end
			LOAD, STORE: aluRes = opA + opImm;	// Base plus offset
			default: aluRes = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			out.valid <= 1'b0;
			tFlag     <= 1'b0;
		end else begin
			if (in.ready)
				out.valid <= in.valid;
			if (accept && opLive && isCmp)
				tFlag <= cmpRes;	// In program order, next op sees it
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			out.uop         <= in.uop;	// valB kept as store data
			out.uop.result  <= dataWord_t'(aluRes);
			out.uop.isLoad  <= (in.uop.cmd == LOAD);
			out.uop.isStore <= (in.uop.cmd == STORE);
			out.uop.live    <= opLive;
		end
	end

endmodule

`default_nettype wire

/* hw/exMemAccess.sv */
//******************************
// EX2 stage with the data scratchpad
// Store write, load read, range check
//******************************
`default_nettype none

module exMemAccess
	import exPkg::*;
#(
	parameter int DATA_W    = exPkg::DATA_W,
	parameter int MEM_DEPTH = exPkg::MEM_DEPTH
) (
	input  wire   clock,
	input  wire   rstN,
	exStageIf.dst in,
	exStageIf.src out
);

	localparam int ADDR_W = $clog2(MEM_DEPTH);	// Word index width

	typedef logic [DATA_W-1:0] word_t;

	word_t             mem [MEM_DEPTH];	// Scratchpad
	logic [ADDR_W-1:0] addrIdx;
	logic              accept;
	logic              memOp;	// Live load or store
	logic              inRange;
	logic              doStore;
	logic              loadHit;

	assign in.ready = !out.valid || out.ready;
	assign accept   = in.valid && in.ready;

	// Address was formed in EX1 and rides in result
	assign memOp   = in.uop.live && (in.uop.isLoad || in.uop.isStore);
	assign inRange = in.uop.result < dataWord_t'(MEM_DEPTH);
	assign addrIdx = in.uop.result[ADDR_W-1:0];
	assign doStore = accept && memOp && in.uop.isStore && inRange;
	assign loadHit = memOp && in.uop.isLoad && inRange;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			out.valid <= 1'b0;
		end else if (in.ready) begin
			out.valid <= in.valid;
		end
	end

	// Scratchpad starts out zeroed
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < MEM_DEPTH; i++)
				mem[i] <= '0;
		end else if (doStore) begin
			mem[addrIdx] <= word_t'(in.uop.valB);
		end
	end

	// Store then load of one address works, the write lands first
	always_ff @(posedge clock) begin
		if (accept) begin
			out.uop <= in.uop;
			if (loadHit)
				out.uop.result <= dataWord_t'(mem[addrIdx]);
			out.uop.fault <= memOp && !inRange;	// Faulting op keeps its address
		end
	end

endmodule

`default_nettype wire

/* hw/exPipeTop.sv */
//******************************
// Execute tail top level
// Ingress, EX1, EX2, EX3 joined by stage links
//******************************
`default_nettype none

module exPipeTop
	import exPkg::*;
#(
	parameter int DATA_W    = exPkg::DATA_W,
	parameter int MEM_DEPTH = exPkg::MEM_DEPTH
) (
	input  wire                 clock,
	input  wire                 rstN,

	input  wire                 inValid,	// Micro-op in
	output logic                inReady,
	input  wire uopCmd_e        inCmd,
	input  wire predMode_e      inPred,
	input  wire [REG_ID_W-1:0]  inRegId,
	input  wire [DATA_W-1:0]    inValA,
	input  wire [DATA_W-1:0]    inValB,
	input  wire [DATA_W-1:0]    inImm,

	input  wire                 memWait,	// Scratchpad not responding

	output logic                wbValid,	// Writeback out
	input  wire                 wbReady,
	output logic [REG_ID_W-1:0] wbRegId,
	output logic [DATA_W-1:0]   wbValue,
	output logic                wbFault
);

	exStageIf ingToEx1 ();
	exStageIf ex1ToEx2 ();
	exStageIf ex2ToEx3 ();

	uopIngress #(
		.DATA_W (DATA_W)
	) uopIngress_i (
		.clock   (clock),
		.rstN    (rstN),
		.inValid (inValid),
		.inReady (inReady),
		.inCmd   (inCmd),
		.inPred  (inPred),
		.inRegId (inRegId),
		.inValA  (inValA),
		.inValB  (inValB),
		.inImm   (inImm),
		.out     (ingToEx1.src)
	);

	exAlu #(
		.DATA_W (DATA_W)
	) exAlu_i (
		.clock (clock),
		.rstN  (rstN),
		.in    (ingToEx1.dst),
		.out   (ex1ToEx2.src)
	);

	exMemAccess #(
		.DATA_W    (DATA_W),
		.MEM_DEPTH (MEM_DEPTH)
	) exMemAccess_i (
		.clock (clock),
		.rstN  (rstN),
		.in    (ex1ToEx2.dst),
		.out   (ex2ToEx3.src)
	);

	exWriteback #(
		.DATA_W (DATA_W)
	) exWriteback_i (
		.clock   (clock),
		.rstN    (rstN),
		.in      (ex2ToEx3.dst),
		.memWait (memWait),
		.wbValid (wbValid),
		.wbReady (wbReady),
		.wbRegId (wbRegId),
		.wbValue (wbValue),
		.wbFault (wbFault)
	);

endmodule

`default_nettype wire

/* hw/exPkg.sv */
//******************************
// Shared definitions for the execute tail
// Micro-op codes, predicate modes and the stage bundle
//******************************
`default_nettype none

package exPkg;

	localparam int DATA_W    = 32;	// Default datapath width
	localparam int MEM_DEPTH = 16;	// Default scratchpad size in words
	localparam int REG_ID_W  = 6;	// Destination register id width

	typedef logic [DATA_W-1:0]   dataWord_t;	// Word as carried in the bundle
	typedef logic [REG_ID_W-1:0] regId_t;	// Id 0 is the zero register

	typedef enum logic [3:0] {
		NOP   = 4'h0,
		ADD   = 4'h1,
		SUB   = 4'h2,
		AND   = 4'h3,
		OR    = 4'h4,
		XOR   = 4'h5,
		SHL   = 4'h6,	// Shift by valB[4:0]
		MOVI  = 4'h7,	// Immediate to Rd
		CMPEQ = 4'h8,	// T = (A == B)
		CMPLT = 4'h9,	// T = (A < B), unsigned
		LOAD  = 4'hA,	// Rd = mem[A + Imm]
		STORE = 4'hB	// mem[A + Imm] = B
	} uopCmd_e;

	typedef enum logic [1:0] {
		ALWAYS = 2'b00,
		IFT    = 2'b01,	// Runs only with T set
		IFF    = 2'b10	// Runs only with T clear
	} predMode_e;

	typedef struct packed {
		uopCmd_e   cmd;
		predMode_e pred;
		regId_t    regIdRd;
		dataWord_t valA;
		dataWord_t valB;	// Also store data
		dataWord_t valImm;
		dataWord_t result;	// ALU result, address, then load data
		logic      isLoad;
		logic      isStore;
		logic      fault;	// Address out of scratchpad range
		logic      live;	// Cleared by predicate squash
	} stageUop_t;

	// Ops that produce a register result
	function automatic logic writesReg(input uopCmd_e cmd);
		case (cmd)
			ADD, SUB, AND, OR, XOR, SHL, MOVI, LOAD: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

/* hw/exStageIf.sv */
//******************************
// Stage-to-stage link with one bundle
// and a valid/ready handshake
//******************************
`default_nettype none

interface exStageIf
	import exPkg::*;
();

	stageUop_t uop;	// Held stable until taken
	logic      valid;
	logic      ready;	// Transfer when valid && ready

	// Upstream side
	modport src (
		output uop,
		output valid,
		input  ready
	);

	// Downstream side
	modport dst (
		input  uop,
		input  valid,
		output ready
	);

endinterface

`default_nettype wire

/* hw/exWriteback.sv */
//******************************
// EX3 stage, result select and memory hold
// Writeback register on the output side
//******************************
`default_nettype none

module exWriteback
	import exPkg::*;
#(
	parameter int DATA_W = exPkg::DATA_W
) (
	input  wire                 clock,
	input  wire                 rstN,
	exStageIf.dst               in,
	input  wire                 memWait,
	output logic                wbValid,
	input  wire                 wbReady,
	output logic [REG_ID_W-1:0] wbRegId,
	output logic [DATA_W-1:0]   wbValue,
	output logic                wbFault
);

	typedef logic [DATA_W-1:0] word_t;

	logic memHold;	// Memory op waiting on the scratchpad
	logic wbFree;	// Writeback register empty or draining
	logic accept;
	logic keep;	// Op shows up on the writeback stream

	assign memHold = in.valid && in.uop.live
		&& (in.uop.isLoad || in.uop.isStore) && memWait;
	assign wbFree  = !wbValid || wbReady;

	assign in.ready = wbFree && !memHold;	// Hold stalls EX2 and up
	assign accept   = in.valid && in.ready;

	// Squashed ops, good stores, compares, NOPs and Rd 0 are dropped
	assign keep = in.uop.live
		&& ((writesReg(in.uop.cmd) && (in.uop.regIdRd != '0)) || in.uop.fault);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else if (wbFree) begin
			wbValid <= accept && keep;
		end
	end

	// Load data was already merged into result by EX2
	always_ff @(posedge clock) begin
		if (accept && keep) begin
			wbRegId <= in.uop.isStore ? '0 : in.uop.regIdRd;	// Store fault has no Rd
			wbValue <= word_t'(in.uop.result);
			wbFault <= in.uop.fault;
		end
	end

endmodule

`default_nettype wire

/* hw/uopIngress.sv */
//******************************
// Micro-op ingress, two-entry skid buffer
// Packs the input fields into a stage bundle
//******************************
`default_nettype none

module uopIngress
	import exPkg::*;
#(
	parameter int DATA_W = exPkg::DATA_W
) (
	input  wire                clock,
	input  wire                rstN,
	input  wire                inValid,
	output logic               inReady,
	input  wire uopCmd_e       inCmd,
	input  wire predMode_e     inPred,
	input  wire [REG_ID_W-1:0] inRegId,
	input  wire [DATA_W-1:0]   inValA,
	input  wire [DATA_W-1:0]   inValB,
	input  wire [DATA_W-1:0]   inImm,
	exStageIf.src              out
);

	stageUop_t inUop;	// Packed input fields
	stageUop_t mainUop;	// Output register
	stageUop_t skidUop;	// Catches one op during a stall
	logic      mainValid;
	logic      skidValid;
	logic      mainLoad;	// Output register may take a new op

	assign inReady  = !skidValid;	// Registered, no path from out.ready
	assign mainLoad = !mainValid || out.ready;

	assign out.valid = mainValid;
	assign out.uop   = mainUop;

	always_comb begin
		inUop         = '0;
		inUop.cmd     = inCmd;
		inUop.pred    = inPred;
		inUop.regIdRd = inRegId;
		inUop.valA    = dataWord_t'(inValA);	// Widen to bundle word
		inUop.valB    = dataWord_t'(inValB);
		inUop.valImm  = dataWord_t'(inImm);
		inUop.live    = 1'b1;	// Predicate decides in EX1
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			mainValid <= 1'b0;
			skidValid <= 1'b0;
		end else if (mainLoad) begin
			mainValid <= skidValid || inValid;	// Skid entry drains first
			skidValid <= 1'b0;
		end else if (inValid && inReady) begin
			skidValid <= 1'b1;	// Downstream stalled, park the op
		end
	end

	always_ff @(posedge clock) begin
		if (mainLoad)
			mainUop <= skidValid ? skidUop : inUop;
		if (!mainLoad && inValid && inReady)
			skidUop <= inUop;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute tail testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module exPipeTb -f filelist.f \
	&& ./obj_dir/VexPipeTb 2>&1 | tee sim.log \
	|| echo "Build or simulation error"

grep -qxF '** PASS **' sim.log \
	&& echo "Simulation passed" \
	&& exit 0
echo "Simulation failed"
exit 1

/* tb/exPipeTb.sv */
//******************************
// Execute tail testbench
// Table stimulus, reference model, random stalls
//******************************
`default_nettype none

module exPipeTb
	import exPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 100;
	localparam int ROWS       = 40;
	localparam int PASSES     = 2;	// Second pass under random stalls
	localparam int TOTAL      = ROWS * PASSES;
	localparam int DEPTH      = 16;	// Scratchpad words

	typedef struct packed {
		uopCmd_e             cmd;
		predMode_e           pred;
		logic [REG_ID_W-1:0] rd;
		logic [DATA_W-1:0]   a;
		logic [DATA_W-1:0]   b;
		logic [DATA_W-1:0]   imm;
	} row_t;

	typedef struct packed {
		logic [REG_ID_W-1:0] rd;
		logic [DATA_W-1:0]   value;
		logic                fault;
	} wbEntry_t;

	// cmd, pred, rd, a, b, imm
	localparam row_t STIM [ROWS] = '{
		'{MOVI,  ALWAYS, 6'd1,  32'h0,        32'h0,        32'h12345678},	// Latency probe
		'{ADD,   ALWAYS, 6'd2,  32'd5,        32'd7,        32'h0},
		'{SUB,   ALWAYS, 6'd3,  32'd3,        32'd5,        32'h0},	// Wraps negative
		'{AND,   ALWAYS, 6'd4,  32'hF0F0F0F0, 32'hFF00FF00, 32'h0},
		'{OR,    ALWAYS, 6'd5,  32'h0F0F0000, 32'h000000F0, 32'h0},
		'{XOR,   ALWAYS, 6'd6,  32'hAAAA5555, 32'hFFFF0000, 32'h0},
		'{SHL,   ALWAYS, 6'd7,  32'h1,        32'h24,       32'h0},	// Only low five bits count
		'{MOVI,  ALWAYS, 6'd0,  32'h0,        32'h0,        32'hDEAD},	// Zero register
		'{NOP,   ALWAYS, 6'd9,  32'h1,        32'h2,        32'h3},
		'{CMPEQ, ALWAYS, 6'd8,  32'd9,        32'd9,        32'h0},	// T set
		'{ADD,   IFT,    6'd10, 32'd1,        32'd2,        32'h0},
		'{ADD,   IFF,    6'd11, 32'd1,        32'd2,        32'h0},
		'{CMPLT, ALWAYS, 6'd0,  32'd10,       32'd3,        32'h0},	// T cleared
		'{MOVI,  IFT,    6'd12, 32'h0,        32'h0,        32'h77},
		'{MOVI,  IFF,    6'd13, 32'h0,        32'h0,        32'h88},
		'{CMPLT, ALWAYS, 6'd0,  32'd3,        32'hFFFFFFFF, 32'h0},	// Unsigned, T set
		'{CMPEQ, IFF,    6'd0,  32'd1,        32'd2,        32'h0},	// Squashed, T stays
		'{XOR,   IFT,    6'd14, 32'hFF,       32'h0F,       32'h0},
		'{STORE, ALWAYS, 6'd0,  32'd4,        32'hCAFEF00D, 32'd1},
		'{LOAD,  ALWAYS, 6'd15, 32'd2,        32'h0,        32'd3},	// Same word just stored
		'{LOAD,  ALWAYS, 6'd16, 32'd0,        32'h0,        32'd9},	// Never written
		'{STORE, ALWAYS, 6'd29, 32'h10,       32'h1111,     32'h0},	// Out of range
		'{LOAD,  ALWAYS, 6'd17, 32'h20,       32'h0,        32'd4},	// Out of range
		'{LOAD,  ALWAYS, 6'd18, 32'd5,        32'h0,        32'h0},
		'{STORE, IFT,    6'd0,  32'd0,        32'hBEEF0001, 32'hF},
		'{STORE, IFF,    6'd0,  32'd0,        32'h0BAD,     32'hF},
		'{LOAD,  IFT,    6'd19, 32'hF,        32'h0,        32'h0},
		'{CMPEQ, ALWAYS, 6'd0,  32'd1,        32'd2,        32'h0},	// T cleared
		'{LOAD,  IFT,    6'd20, 32'd100,      32'h0,        32'h0},	// Squashed fault
		'{STORE, IFF,    6'd0,  32'h40,       32'd5,        32'h0},	// Live fault
		'{LOAD,  ALWAYS, 6'd0,  32'd3,        32'h0,        32'h0},
		'{STORE, ALWAYS, 6'd30, 32'd0,        32'h600DD00D, 32'h0},
		'{LOAD,  ALWAYS, 6'd21, 32'd0,        32'h0,        32'h0},
		'{ADD,   ALWAYS, 6'd22, 32'hFFFFFFFF, 32'd1,        32'h0},
		'{SHL,   ALWAYS, 6'd23, 32'd3,        32'd31,       32'h0},
		'{SUB,   IFF,    6'd24, 32'd100,      32'd1,        32'h0},
		'{MOVI,  ALWAYS, 6'd25, 32'h0,        32'h0,        32'hA5A5A5A5},
		'{LOAD,  ALWAYS, 6'd26, 32'hE,        32'h0,        32'd1},
		'{OR,    ALWAYS, 6'd27, 32'h0,        32'h1,        32'h0},
		'{STORE, ALWAYS, 6'd0,  32'd1,        32'h77,       32'h0}
	};

	logic                clock;
	logic                rstN;
	logic                inValid;
	logic                inReady;
	uopCmd_e             inCmd;
	predMode_e           inPred;
	logic [REG_ID_W-1:0] inRegId;
	logic [DATA_W-1:0]   inValA;
	logic [DATA_W-1:0]   inValB;
	logic [DATA_W-1:0]   inImm;
	logic                memWait;
	logic                wbValid;
	logic                wbReady;
	logic [REG_ID_W-1:0] wbRegId;
	logic [DATA_W-1:0]   wbValue;
	logic                wbFault;

	wbEntry_t expQ [$];	// Model writebacks in program order
	integer   seed;
	logic     randomPhase;	// Stall generator on
	int       cycleCount = 0;
	int       firstIssue = 0;	// Cycle of the first input transfer
	int       wbSeen = 0;

	exPipeTop #(
		.DATA_W    (DATA_W),
		.MEM_DEPTH (DEPTH)
	) exPipeTop_i (
		.clock   (clock),
		.rstN    (rstN),
		.inValid (inValid),
		.inReady (inReady),
		.inCmd   (inCmd),
		.inPred  (inPred),
		.inRegId (inRegId),
		.inValA  (inValA),
		.inValB  (inValB),
		.inImm   (inImm),
		.memWait (memWait),
		.wbValid (wbValid),
		.wbReady (wbReady),
		.wbRegId (wbRegId),
		.wbValue (wbValue),
		.wbFault (wbFault)
	);

	task automatic stopWithFail(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
			stopWithFail($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, want));
	endtask

	// Sequential model of T, scratchpad and predication
	task automatic buildExpected();
		logic              tModel;
		logic [DATA_W-1:0] memModel [DEPTH];
		logic [DATA_W-1:0] addr;
		logic [DATA_W-1:0] res;
		logic              runs;
		row_t              r;
		wbEntry_t          e;
		tModel = 1'b0;
		for (int i = 0; i < DEPTH; i++)
			memModel[i] = '0;
		for (int n = 0; n < TOTAL; n++) begin
			r    = STIM[6'(n % ROWS)];
			runs = (r.pred == ALWAYS) || (r.pred == IFT && tModel) || (r.pred == IFF && !tModel);
			addr = r.a + r.imm;	// Memory ops only
			res  = '0;
			if (runs) begin
				case (r.cmd)
					ADD:     res = r.a + r.b;
					SUB:     res = r.a - r.b;
					AND:     res = r.a & r.b;
					OR:      res = r.a | r.b;
					XOR:     res = r.a ^ r.b;
					SHL:     res = r.a << r.b[4:0];
					MOVI:    res = r.imm;
					CMPEQ:   tModel = (r.a == r.b);
					CMPLT:   tModel = (r.a < r.b);
					LOAD:    res = (addr < DEPTH) ? memModel[addr[3:0]] : '0;
					STORE: begin
						if (addr < DEPTH)
							memModel[addr[3:0]] = r.b;
					end
					default: res = '0;
				endcase
				if (r.cmd inside {LOAD, STORE} && addr >= DEPTH) begin
					e.rd    = (r.cmd == STORE) ? '0 : r.rd;	// Fault reports its address
					e.value = addr;
					e.fault = 1'b1;
					expQ.push_back(e);
				end else if (r.cmd inside {ADD, SUB, AND, OR, XOR, SHL, MOVI, LOAD}
					&& r.rd != '0) begin
					e.rd    = r.rd;
					e.value = res;
					e.fault = 1'b0;
					expQ.push_back(e);
				end
			end
		end
	endtask

	task automatic driveRow(input logic [5:0] idx);
		inValid <= 1'b1;
		inCmd   <= STIM[idx].cmd;
		inPred  <= STIM[idx].pred;
		inRegId <= STIM[idx].rd;
		inValA  <= STIM[idx].a;
		inValB  <= STIM[idx].b;
		inImm   <= STIM[idx].imm;
	endtask

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock)
		cycleCount++;

	// memWait and wbReady, calm and heavy phases
	initial begin
		logic [31:0] r;
		logic [4:0]  phaseCnt;
		seed     = 32'hc320bb5a;
		memWait  = 1'b0;
		wbReady  = 1'b1;
		phaseCnt = '0;
		forever begin
			@(posedge clock);
			if (randomPhase) begin
				r = $random(seed);
				if (phaseCnt[4]) begin
					memWait <= r[0];	// Heavy stalls
					wbReady <= r[1];
				end else begin
					memWait <= (r[3:1] == 3'b000);
					wbReady <= (r[6:4] != 3'b000);
				end
				phaseCnt = phaseCnt + 5'd1;
			end
		end
	end

	// Writeback checker, sampled away from the clock edge
	always @(negedge clock) begin
		wbEntry_t head;
		if (rstN && wbValid && wbReady) begin
			if (expQ.size() == 0) begin
				stopWithFail("a writeback arrived that the model did not expect");
			end else begin
				head = expQ.pop_front();
				if (wbSeen == 0)
					checkValue("latency", 32'(cycleCount - firstIssue), 32'd4);
				checkValue("wbRegId", 32'(wbRegId), 32'(head.rd));
				checkValue("wbValue", wbValue, head.value);
				checkValue("wbFault", 32'(wbFault), 32'(head.fault));
				wbSeen++;
			end
		end
	end

	initial begin
		#(TOTAL * 40 * CLK_PERIOD);
		stopWithFail("timeout, the expected writebacks never arrived");
	end

	initial begin
		int   n;
		logic taken;
		rstN        = 1'b0;
		inValid     = 1'b0;
		inCmd       = NOP;
		inPred      = ALWAYS;
		inRegId     = '0;
		inValA      = '0;
		inValB      = '0;
		inImm       = '0;
		randomPhase = 1'b0;
		buildExpected();
		repeat (4) @(posedge clock);
		rstN <= 1'b1;
		@(posedge clock);
		n = 0;
		driveRow(6'd0);
		while (n < TOTAL) begin
			@(negedge clock);
			taken = inValid && inReady;	// Transfer on the coming edge
			if (taken && n == 0)
				firstIssue = cycleCount;
			if (taken && n == ROWS - 1)
				randomPhase = 1'b1;
			@(posedge clock);
			if (taken) begin
				n++;
				if (n < TOTAL)
					driveRow(6'(n % ROWS));
				else
					inValid <= 1'b0;
			end
		end
		while (expQ.size() != 0)
			@(posedge clock);
		repeat (20) @(posedge clock);	// Catch stray writebacks
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
